/* compile.f */
+incdir+.
xike_pkg.sv
thr_bank.sv
mua_serializer.sv
spk_detect.sv
host_fifo.sv
xike_top.sv
tb_xike.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_xike -f compile.f -o sim_tb_xike

out=$(./obj_dir/sim_tb_xike)
echo "$out"

if grep -qx "all tests passed" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* xike_stimulus.txt */
# W addr thr | R addr expected | S level | C ch0..ch4 s0..s4 | D (drain) | E test_name
# All values hex, samples and thresholds 16-bit two's complement
W 03 ff9c
W 1f 8001
R 03 ff9c
R 1f 8001
R 0a 0000
E thr_readback
S 1
C 01 02 03 04 05 0011 0022 0033 0044 0055
D
E serialize
W 07 0064
C 07 07 07 07 07 00c8 005a 0050 0096 0032
C 07 07 07 07 07 0028 012c 000a 0064 00c8
D
E first_crossing
S 0
S 1
C 03 1f 09 09 09 ff00 8000 0100 0100 0100
C 09 09 09 09 09 0100 0100 0100 0100 ff00
D
E frame_restart
C 00 01 02 04 05 0101 0102 0103 0104 0105
C 00 01 02 04 05 0201 0202 0203 0204 0205
C 00 01 02 04 05 0301 0302 0303 0304 0305
C 00 01 02 04 05 0401 0402 0403 0404 0405
C 00 01 02 04 05 0501 0502 0503 0504 0505
C 00 01 02 04 05 0601 0602 0603 0604 0605
C 00 01 02 04 05 0701 0702 0703 0704 0705
D
E overflow

/* tb_xike.sv */
`timescale 1ns/1ps
`include "xike_defines.svh"

module tb_xike;

  import xike_pkg::*;

  logic                      bus_clk;
  logic                      reset;
  logic                      thr_wr;
  logic                      thr_rd;
  logic [`XIKE_CH_W-1:0]     thr_addr;
  logic [`XIKE_SAMPLE_W-1:0] thr_wdata;
  logic [`XIKE_SAMPLE_W-1:0] thr_rdata;
  logic                      spi_running;
  logic                      mua_comb_valid;
  mua_comb_t                 mua_comb;
  logic                      mua_comb_ready;
  logic                      mua_rd;
  host_word_t                mua_data;
  logic                      mua_empty;
  logic                      spk_rd;
  host_word_t                spk_data;
  logic                      spk_empty;
  logic                      overflow;

  // Reference model state
  logic [`XIKE_SAMPLE_W-1:0] thr_m [`XIKE_NUM_CH];
  bit                        below_m [`XIKE_NUM_CH];
  logic [`XIKE_FRAME_W-1:0]  frame_m;
  bit                        running_m;
  bit                        ovf_m;
  host_word_t                mua_q [$];
  host_word_t                spk_q [$];

  int test_errs;
  int err_total;
  int n_tests;
  int n_failed;
  int cycle_cnt;
  int cycle_limit;

  xike_top i_dut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  // Watchdog, limit set once the stimulus length is known
  always @(posedge bus_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run stopped: no progress within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  task automatic value_error(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("** Error: %s = %h, expected %h", sig, got, exp);
    test_errs++;
    err_total++;
  endtask

  task automatic plain_error(input string msg);
    $display("Error: %s", msg);
    test_errs++;
    err_total++;
  endtask

  task automatic wait_ready();
    while (!mua_comb_ready) begin
      @(negedge bus_clk);
    end
  endtask

  // Serializer idle, then the last lane reaches its FIFO
  task automatic flush_pipeline();
    wait_ready();
    repeat (2) @(negedge bus_clk);
  endtask

  task automatic write_threshold(input logic [31:0] addr, input logic [31:0] val);
    flush_pipeline();
    thr_addr  = addr[`XIKE_CH_W-1:0];
    thr_wdata = val[`XIKE_SAMPLE_W-1:0];
    thr_wr    = 1'b1;
    @(negedge bus_clk);
    thr_wr = 1'b0;
    thr_m[addr[`XIKE_CH_W-1:0]] = val[`XIKE_SAMPLE_W-1:0];
  endtask

  task automatic read_threshold(input logic [31:0] addr, input logic [31:0] exp);
    flush_pipeline();
    thr_addr = addr[`XIKE_CH_W-1:0];
    thr_rd   = 1'b1;
    @(negedge bus_clk);
    thr_rd = 1'b0;
    assert (thr_rdata == exp[`XIKE_SAMPLE_W-1:0])
      else value_error("thr_rdata", 32'(thr_rdata), exp);
  endtask

  task automatic set_running(input logic level);
    flush_pipeline();
    spi_running = level;
    @(negedge bus_clk);
    running_m = level;
    if (!level) begin
      frame_m = '0;
      foreach (below_m[i]) begin
        below_m[i] = 1'b0;
      end
    end
  endtask

  // Expected words for one beat, lane by lane
  task automatic predict_beat(input mua_comb_t comb);
    host_word_t                      w;
    logic [`XIKE_CH_W-1:0]           ch;
    logic signed [`XIKE_SAMPLE_W-1:0] s;
    logic signed [`XIKE_SAMPLE_W-1:0] t;
    bit                              hit;
    for (int k = 0; k < `XIKE_LANES; k++) begin
      ch     = comb.ch[k];
      s      = comb.sample[k];
      t      = thr_m[ch];
      hit    = (s <= t);
      w.ch   = 16'(ch);
      w.data = s;
      if (mua_q.size() < `XIKE_FIFO_DEPTH) mua_q.push_back(w);
      else ovf_m = 1'b1;
      if (hit && !below_m[ch]) begin
        w.data = frame_m;
        if (spk_q.size() < `XIKE_FIFO_DEPTH) spk_q.push_back(w);
        else ovf_m = 1'b1;
      end
      below_m[ch] = running_m ? hit : 1'b0;
    end
    if (running_m) begin
      frame_m = frame_m + 1'b1;
    end
  endtask

  task automatic send_comb(input mua_comb_t comb);
    wait_ready();
    mua_comb       = comb;
    mua_comb_valid = 1'b1;
    @(negedge bus_clk);
    mua_comb_valid = 1'b0;
    predict_beat(comb);
  endtask

  task automatic drain_fifo(input bit is_spk);
    host_word_t exp;
    host_word_t got;
    logic       empty_now;
    int         n;
    n = is_spk ? spk_q.size() : mua_q.size();
    for (int i = 0; i < n; i++) begin
      if (is_spk) exp = spk_q.pop_front();
      else exp = mua_q.pop_front();
      got       = is_spk ? spk_data : mua_data;
      empty_now = is_spk ? spk_empty : mua_empty;
      assert (!empty_now)
        else plain_error($sformatf("%s FIFO empty before word %0d",
                                   is_spk ? "spike" : "MUA", i));
      assert (got == exp)
        else value_error(is_spk ? "spk_data" : "mua_data", got, exp);
      if (is_spk) spk_rd = 1'b1;
      else mua_rd = 1'b1;
      @(negedge bus_clk);
      spk_rd = 1'b0;
      mua_rd = 1'b0;
    end
    empty_now = is_spk ? spk_empty : mua_empty;
    assert (empty_now)
      else plain_error($sformatf("%s FIFO holds more words than expected",
                                 is_spk ? "spike" : "MUA"));
  endtask

  task automatic finish_test(input logic [8*32-1:0] name);
    n_tests++;
    if (test_errs == 0) begin
      $display("test %0d %0s: ok", n_tests, name);
    end else begin
      n_failed++;
      $display("test %0d %0s: FAILED with %0d errors", n_tests, name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    int               fd;
    int               c;
    int               code;
    int               n_lines;
    bit               done;
    logic [7:0]       cmd;
    logic [31:0]      a;
    logic [31:0]      v;
    logic [8*32-1:0]  name;
    mua_comb_t        comb;

    reset          = 1'b1;
    thr_wr         = 1'b0;
    thr_rd         = 1'b0;
    thr_addr       = '0;
    thr_wdata      = '0;
    spi_running    = 1'b0;
    mua_comb_valid = 1'b0;
    mua_comb       = '0;
    mua_rd         = 1'b0;
    spk_rd         = 1'b0;
    cycle_cnt      = 0;
    cycle_limit    = 200;
    test_errs      = 0;
    err_total      = 0;
    n_tests        = 0;
    n_failed       = 0;
    n_lines        = 0;
    done           = 1'b0;
    frame_m        = '0;
    running_m      = 1'b0;
    ovf_m          = 1'b0;
    foreach (thr_m[i]) begin
      thr_m[i]   = '0;
      below_m[i] = 1'b0;
    end

    repeat (10) @(posedge bus_clk);
    @(negedge bus_clk);
    reset = 1'b0;
    assert (mua_comb_ready && mua_empty && spk_empty && !overflow)
      else plain_error("outputs not at their reset values");

    fd = $fopen("xike_stimulus.txt", "r");
    if (fd == 0) begin
      plain_error("cannot open xike_stimulus.txt");
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == 10) n_lines++;
        c = $fgetc(fd);
      end
      $fclose(fd);
      cycle_limit = cycle_cnt + n_lines * 40 + 200;
      fd = $fopen("xike_stimulus.txt", "r");
      while (!done) begin
        code = $fscanf(fd, " %c", cmd);
        if (code != 1) begin
          done = 1'b1;
        end else begin
          case (cmd)
            "#": begin
              c = $fgetc(fd);
              while (c != 10 && c != -1) c = $fgetc(fd);
            end
            "W": begin
              code = $fscanf(fd, "%h %h", a, v);
              write_threshold(a, v);
            end
            "R": begin
              code = $fscanf(fd, "%h %h", a, v);
              read_threshold(a, v);
            end
            "S": begin
              code = $fscanf(fd, "%h", v);
              set_running(v[0]);
            end
            "C": begin
              for (int k = 0; k < `XIKE_LANES; k++) begin
                code = $fscanf(fd, "%h", v);
                comb.ch[k] = v[`XIKE_CH_W-1:0];
              end
              for (int k = 0; k < `XIKE_LANES; k++) begin
                code = $fscanf(fd, "%h", v);
                comb.sample[k] = v[`XIKE_SAMPLE_W-1:0];
              end
              send_comb(comb);
            end
            "D": begin
              flush_pipeline();
              drain_fifo(1'b0);
              drain_fifo(1'b1);
              assert (overflow == ovf_m)
                else value_error("overflow", 32'(overflow), 32'(ovf_m));
            end
            "E": begin
              code = $fscanf(fd, "%s", name);
              finish_test(name);
            end
            default: plain_error($sformatf("unknown stimulus command '%c'", cmd));
          endcase
        end
      end
      $fclose(fd);
    end

    $display("Summary: %0d tests run, %0d passed, %0d failed, %0d check errors",
             n_tests, n_tests - n_failed, n_failed, err_total);
    if (n_failed == 0 && err_total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* xike_top.sv */
`timescale 1ns/1ps
`include "xike_defines.svh"

module xike_top (
  input  logic                      bus_clk,
  input  logic                      reset,
  input  logic                      thr_wr,
  input  logic                      thr_rd,
  input  logic [`XIKE_CH_W-1:0]     thr_addr,
  input  logic [`XIKE_SAMPLE_W-1:0] thr_wdata,
  output logic [`XIKE_SAMPLE_W-1:0] thr_rdata,
  input  logic                      spi_running,
  input  logic                      mua_comb_valid,
  input  xike_pkg::mua_comb_t       mua_comb,
  output logic                      mua_comb_ready,
  input  logic                      mua_rd,
  output xike_pkg::host_word_t      mua_data,
  output logic                      mua_empty,
  input  logic                      spk_rd,
  output xike_pkg::host_word_t      spk_data,
  output logic                      spk_empty,
  output logic                      overflow
);

  import xike_pkg::*;

  mua_beat_t                 beat;
  logic                      beat_valid;
  logic [`XIKE_SAMPLE_W-1:0] lookup_thr;
  host_word_t                mua_word;
  host_word_t                spk_word;
  logic                      mua_wr;
  logic                      spk_wr;
  logic                      ovf_mua;
  logic                      ovf_spk;

  thr_bank i_thr_bank (
    .bus_clk    (bus_clk),
    .reset      (reset),
    .thr_wr     (thr_wr),
    .thr_rd     (thr_rd),
    .thr_addr   (thr_addr),
    .thr_wdata  (thr_wdata),
    .thr_rdata  (thr_rdata),
    .lookup_ch  (beat.ch),
    .lookup_thr (lookup_thr)
  );

  mua_serializer i_mua_serializer (
    .bus_clk        (bus_clk),
    .reset          (reset),
    .spi_running    (spi_running),
    .mua_comb_valid (mua_comb_valid),
    .mua_comb       (mua_comb),
    .mua_comb_ready (mua_comb_ready),
    .beat_valid     (beat_valid),
    .beat           (beat)
  );

  spk_detect i_spk_detect (
    .bus_clk     (bus_clk),
    .reset       (reset),
    .spi_running (spi_running),
    .beat_valid  (beat_valid),
    .beat        (beat),
    .thr         (lookup_thr),
    .mua_wr      (mua_wr),
    .spk_wr      (spk_wr),
    .mua_word    (mua_word),
    .spk_word    (spk_word)
  );

  // Every sample word
  host_fifo i_mua_fifo (
    .bus_clk (bus_clk),
    .reset   (reset),
    .wr      (mua_wr),
    .wdata   (mua_word),
    .rd      (mua_rd),
    .rdata   (mua_data),
    .empty   (mua_empty),
    .ovf     (ovf_mua)
  );

  // Channel and frame of each spike
  host_fifo i_spk_fifo (
    .bus_clk (bus_clk),
    .reset   (reset),
    .wr      (spk_wr),
    .wdata   (spk_word),
    .rd      (spk_rd),
    .rdata   (spk_data),
    .empty   (spk_empty),
    .ovf     (ovf_spk)
  );

  // Sticky until reset
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (ovf_mua || ovf_spk) begin
      overflow <= 1'b1;
    end
  end

endmodule

/* host_fifo.sv */
`timescale 1ns/1ps
`include "xike_defines.svh"

module host_fifo #(
  parameter int DEPTH = `XIKE_FIFO_DEPTH
) (
  input  logic                 bus_clk,
  input  logic                 reset,
  input  logic                 wr,
  input  xike_pkg::host_word_t wdata,
  input  logic                 rd,
  output xike_pkg::host_word_t rdata,
  output logic                 empty,
  output logic                 ovf
);

  import xike_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  host_word_t      mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            full;
  logic            do_wr;
  logic            do_rd;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);
  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;
  // One pulse per dropped word
  assign ovf   = wr && full;

  // First word fall through
  assign rdata = mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge bus_clk) disable iff (reset)
    count <= CW'(DEPTH)
  ) else $error("host_fifo: fill count above DEPTH");

endmodule

/* spk_detect.sv */
`timescale 1ns/1ps
`include "xike_defines.svh"

module spk_detect (
  input  logic                      bus_clk,
  input  logic                      reset,
  input  logic                      spi_running,
  input  logic                      beat_valid,
  input  xike_pkg::mua_beat_t       beat,
  input  logic [`XIKE_SAMPLE_W-1:0] thr,
  output logic                      mua_wr,
  output logic                      spk_wr,
  output xike_pkg::host_word_t      mua_word,
  output xike_pkg::host_word_t      spk_word
);

  localparam int PAD_W = `XIKE_WORD_W / 2 - `XIKE_CH_W;

  // Set while a channel sits at or under its threshold
  logic [`XIKE_NUM_CH-1:0]  below;
  logic                     is_below;
  logic [`XIKE_WORD_W/2-1:0] ch_ext;

  assign is_below = $signed(beat.sample) <= $signed(thr);
  assign ch_ext   = {{PAD_W{1'b0}}, beat.ch};

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      mua_wr <= 1'b0;
      spk_wr <= 1'b0;
      below  <= '0;
    end else begin
      mua_wr <= beat_valid;
      // Spike only on the first crossing
      spk_wr <= beat_valid && is_below && !below[beat.ch];

      if (!spi_running) begin
        below <= '0;
      end else if (beat_valid) begin
        below[beat.ch] <= is_below;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (beat_valid) begin
      mua_word.ch   <= ch_ext;
      mua_word.data <= beat.sample;
      spk_word.ch   <= ch_ext;
      spk_word.data <= beat.frame;
    end
  end

  a_spk_has_mua: assert property (
    @(posedge bus_clk) disable iff (reset)
    spk_wr |-> mua_wr
  ) else $error("spk_detect: spike word without MUA word");

endmodule

/* mua_serializer.sv */
`timescale 1ns/1ps
`include "xike_defines.svh"

module mua_serializer (
  input  logic                 bus_clk,
  input  logic                 reset,
  input  logic                 spi_running,
  input  logic                 mua_comb_valid,
  input  xike_pkg::mua_comb_t  mua_comb,
  output logic                 mua_comb_ready,
  output logic                 beat_valid,
  output xike_pkg::mua_beat_t  beat
);

  import xike_pkg::*;

  localparam int IDX_W = $clog2(`XIKE_LANES + 1);

  ser_state_e              state;
  logic [IDX_W-1:0]        lane_idx;
  logic [`XIKE_FRAME_W-1:0] frame_cnt;
  logic [`XIKE_FRAME_W-1:0] frame_q;
  mua_comb_t               comb_q;

  mua_comb_t               src;
  logic [`XIKE_FRAME_W-1:0] frame_src;
  logic                    accept;
  logic                    emit;

  assign mua_comb_ready = (state == SER_IDLE);
  assign accept         = mua_comb_valid && mua_comb_ready;

  // Lane 0 comes straight from the input, the rest from the latched beat
  assign src       = (state == SER_IDLE) ? mua_comb : comb_q;
  assign frame_src = (state == SER_IDLE) ? frame_cnt : frame_q;
  assign emit      = accept ||
                     (state == SER_SHIFT && lane_idx != IDX_W'(`XIKE_LANES));

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      state      <= SER_IDLE;
      lane_idx   <= '0;
      beat_valid <= 1'b0;
      frame_cnt  <= '0;
    end else begin
      beat_valid <= emit;
      // lane_idx points at the next lane to send
      lane_idx   <= emit ? lane_idx + 1'b1 : '0;

      case (state)
        SER_IDLE: begin
          if (accept) begin
            state <= SER_SHIFT;
          end
        end
        SER_SHIFT: begin
          if (!emit) begin
            state <= SER_IDLE;
          end
        end
        default: state <= SER_IDLE;
      endcase

      // Frame count restarts whenever acquisition stops
      if (!spi_running) begin
        frame_cnt <= '0;
      end else if (accept) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (accept) begin
      comb_q  <= mua_comb;
      frame_q <= frame_cnt;
    end
    if (emit) begin
      beat.ch     <= src.ch[lane_idx];
      beat.sample <= src.sample[lane_idx];
      beat.frame  <= frame_src;
    end
  end

  a_valid_in_shift: assert property (
    @(posedge bus_clk) disable iff (reset)
    beat_valid |-> state == SER_SHIFT
  ) else $error("mua_serializer: beat_valid outside SER_SHIFT");

endmodule

/* thr_bank.sv */
`timescale 1ns/1ps
`include "xike_defines.svh"

module thr_bank (
  input  logic                      bus_clk,
  input  logic                      reset,
  input  logic                      thr_wr,
  input  logic                      thr_rd,
  input  logic [`XIKE_CH_W-1:0]     thr_addr,
  input  logic [`XIKE_SAMPLE_W-1:0] thr_wdata,
  output logic [`XIKE_SAMPLE_W-1:0] thr_rdata,
  input  logic [`XIKE_CH_W-1:0]     lookup_ch,
  output logic [`XIKE_SAMPLE_W-1:0] lookup_thr
);

  // One threshold per channel
  logic [`XIKE_SAMPLE_W-1:0] thr_mem [`XIKE_NUM_CH];

  // Host writes, table starts out all zero
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      for (int i = 0; i < `XIKE_NUM_CH; i++) begin
        thr_mem[i] <= '0;
      end
    end else if (thr_wr) begin
      thr_mem[thr_addr] <= thr_wdata;
    end
  end

  // Host readback, valid the cycle after the strobe
  always_ff @(posedge bus_clk) begin
    if (thr_rd) begin
      thr_rdata <= thr_mem[thr_addr];
    end
  end

  // Detector side lookup
  assign lookup_thr = thr_mem[lookup_ch];

  // Host never writes and reads the table in one cycle
  a_no_wr_rd_overlap: assert property (
    @(posedge bus_clk) disable iff (reset)
    !(thr_wr && thr_rd)
  ) else $error("thr_bank: thr_wr and thr_rd high together");

endmodule

/* xike_pkg.sv */
`include "xike_defines.svh"

package xike_pkg;

  // One filtered beat, lane k uses ch[k] and sample[k]
  // Samples are two's complement
  typedef struct packed {
    logic [`XIKE_LANES-1:0][`XIKE_CH_W-1:0]     ch;
    logic [`XIKE_LANES-1:0][`XIKE_SAMPLE_W-1:0] sample;
  } mua_comb_t;

  // Single serialized sample with its frame stamp
  typedef struct packed {
    logic [`XIKE_CH_W-1:0]            ch;
    logic signed [`XIKE_SAMPLE_W-1:0] sample;
    logic [`XIKE_FRAME_W-1:0]         frame;
  } mua_beat_t;

  // Host word, channel in the upper half
  // Lower half is the sample or the frame
  typedef struct packed {
    logic [`XIKE_WORD_W/2-1:0] ch;
    logic [`XIKE_WORD_W/2-1:0] data;
  } host_word_t;

  typedef enum logic {
    SER_IDLE,
    SER_SHIFT
  } ser_state_e;

endpackage

/* xike_defines.svh */
`ifndef XIKE_DEFINES_SVH
`define XIKE_DEFINES_SVH

// Samples carried by one comb beat
`define XIKE_LANES 5

// Channel space and threshold table size
`define XIKE_NUM_CH 32
`define XIKE_CH_W 5

// Signed sample and threshold width
`define XIKE_SAMPLE_W 16

// Frame counter width
`define XIKE_FRAME_W 16

// Host side
`define XIKE_FIFO_DEPTH 16
`define XIKE_WORD_W 32

`endif
